// ==== logic/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    // cache geometry, all addresses are word addresses
    localparam int ADDR_WIDTH  = 16;
    localparam int INDEX_WIDTH = 6;                        // 64 lines
    localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH;
    localparam int NUM_LINES   = 1 << INDEX_WIDTH;

    localparam int WORD_BYTES  = 4;
    localparam int WORD_WIDTH  = 8 * WORD_BYTES;

    typedef logic [WORD_WIDTH-1:0]  word_t;
    typedef logic [ADDR_WIDTH-1:0]  addr_t;
    typedef logic [INDEX_WIDTH-1:0] index_t;
    typedef logic [TAG_WIDTH-1:0]   tag_t;
    typedef logic [WORD_BYTES-1:0]  be_t;   // one bit per byte lane

endpackage

// ==== logic/cache_bus_pkg.sv ====
package cache_bus_pkg;
    import cache_cfg_pkg::*;

    // processor side request, held stable while i_cpu_req is high
    typedef struct packed {
        logic  wr;      // 1 = write, 0 = read
        addr_t addr;
        word_t wdata;   // ignored on reads
        be_t   be;      // byte enables for writes
    } cpu_req_t;

    // request towards backing memory
    // same layout as the cpu side, writes go through unchanged
    typedef struct packed {
        logic  wr;
        addr_t addr;
        word_t wdata;
        be_t   be;
    } mem_req_t;

    // one entry of the tag ram
    typedef struct packed {
        logic valid;
        tag_t tag;      // upper address bits of the resident word
    } tag_entry_t;

endpackage

// ==== logic/fwd_ram.sv ====
`timescale 1ns/100ps

module fwd_ram #(
    parameter type T_ENTRY    = logic [31:0],
    parameter int  LANES      = 4,
    parameter int  DEPTH_BITS = 6
) (
    input  logic                  i_clk,
    input  logic                  i_rst,

    input  logic                  i_ren,
    input  logic                  i_wen,
    input  logic [DEPTH_BITS-1:0] i_raddr,
    input  logic [DEPTH_BITS-1:0] i_waddr,
    input  logic [LANES-1:0]      i_wlanes,
    input  T_ENTRY                i_wdata,
    output T_ENTRY                o_rdata
);

    localparam int WIDTH  = $bits(T_ENTRY);
    localparam int LANE_W = WIDTH / LANES;
    localparam int DEPTH  = 1 << DEPTH_BITS;

    logic [WIDTH-1:0] mem [DEPTH];

    logic [WIDTH-1:0]      w_wbits;
    logic [WIDTH-1:0]      r_rbits;     // array output, old contents on collision
    logic [WIDTH-1:0]      w_merged;
    logic [WIDTH-1:0]      r_wbits;
    logic [LANES-1:0]      r_wlanes;
    logic [DEPTH_BITS-1:0] r_raddr;
    logic [DEPTH_BITS-1:0] r_waddr;
    logic                  r_ren;
    logic                  r_wen;
    logic                  w_isforward;

    if (LANE_W * LANES != WIDTH) begin : g_bad_lanes
        $error("fwd_ram: entry width %0d does not split into %0d lanes", WIDTH, LANES);
    end

    assign w_wbits = i_wdata;

    // inferred simple dual port array, registered read
    always_ff @(posedge i_clk) begin
        if (i_wen) begin
            for (int l = 0; l < LANES; l++) begin
                if (i_wlanes[l]) begin
                    mem[i_waddr][l*LANE_W +: LANE_W] <= w_wbits[l*LANE_W +: LANE_W];
                end
            end
        end
        if (i_ren) begin
            r_rbits <= mem[i_raddr];
        end
    end

    // forwarding state, tracks the write seen alongside the read
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_ren    <= 1'b0;
            r_wen    <= 1'b0;
            r_raddr  <= '0;
            r_waddr  <= '0;
            r_wlanes <= '0;
            r_wbits  <= '0;
        end else begin
            r_ren    <= i_ren;
            r_wen    <= i_wen;
            r_raddr  <= i_raddr;
            r_waddr  <= i_waddr;
            r_wlanes <= i_wlanes;
            r_wbits  <= w_wbits;    // write payload
        end
    end

    assign w_isforward = r_ren && r_wen && (r_raddr == r_waddr);

    // written lanes win over the stale array word
    always_comb begin
        w_merged = r_rbits;
        if (w_isforward) begin
            for (int l = 0; l < LANES; l++) begin
                if (r_wlanes[l]) begin
                    w_merged[l*LANE_W +: LANE_W] = r_wbits[l*LANE_W +: LANE_W];
                end
            end
        end
    end

    assign o_rdata = T_ENTRY'(w_merged);

    // the owner of the write port never issues an empty write
    a_wlanes_set: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wen |-> (i_wlanes != '0))
        else $error("fwd_ram: write enable with no lanes selected");

endmodule

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl
    import cache_cfg_pkg::*, cache_bus_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,

    // processor side, four phase
    input  logic       i_cpu_req,
    input  cpu_req_t   i_cpu_pkt,
    output logic       o_cpu_ack,
    output word_t      o_cpu_rdata,

    // backing memory side, four phase
    output logic       o_mem_req,
    output mem_req_t   o_mem_pkt,
    input  logic       i_mem_ack,
    input  word_t      i_mem_rdata,

    // shared ram controls
    output logic       o_ram_ren,
    output logic       o_ram_wen,
    output index_t     o_ram_raddr,
    output index_t     o_ram_waddr,
    output be_t        o_data_lanes,
    output tag_entry_t o_tag_wdata,
    output word_t      o_data_wdata,
    input  tag_entry_t i_tag_rdata,
    input  word_t      i_data_rdata
);

    typedef enum logic [2:0] {
        ST_INIT,        // clearing valid bits
        ST_IDLE,
        ST_LOOKUP,      // ram read
        ST_COMPARE,     // tag check
        ST_MEM_REQ,     // memory req high, waiting for ack
        ST_MEM_REL,     // req dropped, waiting for ack to fall
        ST_RESPOND      // cpu ack high until req drops
    } state_t;

    state_t   r_state;
    index_t   r_init_idx;
    cpu_req_t r_req;        // current transaction
    logic     r_hit;        // write hit, kept for the memory phase

    index_t   w_index;
    tag_t     w_tag;
    logic     w_hit;
    logic     w_mem_done;

    // split the latched address
    assign w_index = r_req.addr[INDEX_WIDTH-1:0];
    assign w_tag   = r_req.addr[ADDR_WIDTH-1:INDEX_WIDTH];

    assign w_hit      = i_tag_rdata.valid && (i_tag_rdata.tag == w_tag);
    assign w_mem_done = (r_state == ST_MEM_REQ) && i_mem_ack;

    assign o_ram_ren   = (r_state == ST_LOOKUP);
    assign o_ram_raddr = w_index;

    // ram write port, init walk or end of memory handshake
    always_comb begin
        o_ram_wen    = 1'b0;
        o_ram_waddr  = w_index;
        o_data_lanes = '0;
        o_tag_wdata  = '{valid: 1'b1, tag: w_tag};
        o_data_wdata = r_req.wdata;
        if (r_state == ST_INIT) begin
            o_ram_wen    = 1'b1;
            o_ram_waddr  = r_init_idx;
            o_data_lanes = '1;
            o_tag_wdata  = '0;     // valid cleared
            o_data_wdata = '0;
        end else if (w_mem_done) begin
            if (!r_req.wr) begin
                // refill the whole line from memory
                o_ram_wen    = 1'b1;
                o_data_lanes = '1;
                o_data_wdata = i_mem_rdata;
            end else if (r_hit && (r_req.be != '0)) begin
                o_ram_wen    = 1'b1;    // write hit, tag rewritten unchanged
                o_data_lanes = r_req.be;
            end
        end
    end

    // control state
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            r_state    <= ST_INIT;
            r_init_idx <= '0;
            r_hit      <= 1'b0;
            o_cpu_ack  <= 1'b0;
            o_mem_req  <= 1'b0;
        end else begin
            case (r_state)
                ST_INIT: begin
                    r_init_idx <= r_init_idx + 1'b1;
                    if (r_init_idx == index_t'(NUM_LINES - 1)) begin
                        r_state <= ST_IDLE;
                    end
                end
                ST_IDLE: begin
                    if (i_cpu_req) begin
                        r_state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    r_state <= ST_COMPARE;
                end
                ST_COMPARE: begin
                    r_hit <= w_hit;
                    if (!r_req.wr && w_hit) begin
                        o_cpu_ack <= 1'b1;     // read hit, answer from the ram
                        r_state   <= ST_RESPOND;
                    end else begin
                        o_mem_req <= 1'b1;     // read miss or write through
                        r_state   <= ST_MEM_REQ;
                    end
                end
                ST_MEM_REQ: begin
                    if (i_mem_ack) begin
                        o_mem_req <= 1'b0;
                        o_cpu_ack <= 1'b1;
                        r_state   <= ST_MEM_REL;
                    end
                end
                ST_MEM_REL: begin
                    if (!i_mem_ack) begin
                        r_state <= ST_RESPOND;
                    end
                end
                ST_RESPOND: begin
                    if (!i_cpu_req) begin
                        o_cpu_ack <= 1'b0;
                        r_state   <= ST_IDLE;
                    end
                end
                default: begin
                    r_state <= ST_INIT;
                end
            endcase
        end
    end

    // payload registers
    always_ff @(posedge i_clk) begin
        if ((r_state == ST_IDLE) && i_cpu_req) begin
            r_req <= i_cpu_pkt;
        end
        if (r_state == ST_COMPARE) begin
            o_mem_pkt <= '{wr: r_req.wr, addr: r_req.addr, wdata: r_req.wdata, be: r_req.be};
            if (!r_req.wr) begin
                o_cpu_rdata <= i_data_rdata;   // only used on a hit
            end
        end
        if (w_mem_done && !r_req.wr) begin
            o_cpu_rdata <= i_mem_rdata;
        end
    end

    // memory sees a steady packet for the whole request
    a_mem_pkt_stable: assert property (@(posedge i_clk) disable iff (i_rst)
        (o_mem_req && $past(o_mem_req)) |-> $stable(o_mem_pkt))
        else $error("dcache_ctrl: memory packet changed during request");

    // ack was registered while req was still high
    a_ack_needs_req: assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_cpu_ack) |-> $past(i_cpu_req))
        else $error("dcache_ctrl: cpu ack raised without a request");

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top
    import cache_cfg_pkg::*, cache_bus_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,

    input  logic     i_cpu_req,
    input  cpu_req_t i_cpu_pkt,
    output logic     o_cpu_ack,
    output word_t    o_cpu_rdata,

    output logic     o_mem_req,
    output mem_req_t o_mem_pkt,
    input  logic     i_mem_ack,
    input  word_t    i_mem_rdata
);

    logic       w_ram_ren;
    logic       w_ram_wen;
    index_t     w_ram_raddr;
    index_t     w_ram_waddr;
    be_t        w_data_lanes;
    tag_entry_t w_tag_wdata;
    tag_entry_t w_tag_rdata;
    word_t      w_data_wdata;
    word_t      w_data_rdata;

    dcache_ctrl u_ctrl (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_cpu_req    (i_cpu_req),
        .i_cpu_pkt    (i_cpu_pkt),
        .o_cpu_ack    (o_cpu_ack),
        .o_cpu_rdata  (o_cpu_rdata),
        .o_mem_req    (o_mem_req),
        .o_mem_pkt    (o_mem_pkt),
        .i_mem_ack    (i_mem_ack),
        .i_mem_rdata  (i_mem_rdata),
        .o_ram_ren    (w_ram_ren),
        .o_ram_wen    (w_ram_wen),
        .o_ram_raddr  (w_ram_raddr),
        .o_ram_waddr  (w_ram_waddr),
        .o_data_lanes (w_data_lanes),
        .o_tag_wdata  (w_tag_wdata),
        .o_data_wdata (w_data_wdata),
        .i_tag_rdata  (w_tag_rdata),
        .i_data_rdata (w_data_rdata)
    );

    // tag ram, whole entry in a single lane
    fwd_ram #(
        .T_ENTRY    (tag_entry_t),
        .LANES      (1),
        .DEPTH_BITS (INDEX_WIDTH)
    ) u_tag_ram (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_ren    (w_ram_ren),
        .i_wen    (w_ram_wen),
        .i_raddr  (w_ram_raddr),
        .i_waddr  (w_ram_waddr),
        .i_wlanes (1'b1),
        .i_wdata  (w_tag_wdata),
        .o_rdata  (w_tag_rdata)
    );

    fwd_ram #(
        .T_ENTRY    (word_t),
        .LANES      (WORD_BYTES),
        .DEPTH_BITS (INDEX_WIDTH)
    ) u_data_ram (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_ren    (w_ram_ren),
        .i_wen    (w_ram_wen),
        .i_raddr  (w_ram_raddr),
        .i_waddr  (w_ram_waddr),
        .i_wlanes (w_data_lanes),
        .i_wdata  (w_data_wdata),
        .o_rdata  (w_data_rdata)
    );

endmodule

// ==== sim/tb_mem_model.sv ====
`timescale 1ns/100ps

module tb_mem_model
    import cache_cfg_pkg::*, cache_bus_pkg::*;
#(
    parameter int          MAX_DELAY = 8,
    parameter logic [31:0] SEED      = 32'h959b_dfe9
) (
    input  logic     i_clk,
    input  logic     i_mem_req,
    input  mem_req_t i_mem_pkt,
    output logic     o_mem_ack,
    output word_t    o_mem_rdata,
    output int       o_req_count
);

    word_t       mem [1 << ADDR_WIDTH];
    logic [31:0] r_seed;

    // both halves depend on every address bit
    function automatic word_t fill_word(input addr_t a);
        return {~a, a ^ 16'h5a3c};
    endfunction

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin : p_fill
        for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
            mem[a] = fill_word(addr_t'(a));
        end
    end

    // four phase slave, outputs change on the falling edge
    initial begin : p_serve
        int delay;
        r_seed      = SEED;
        o_mem_ack   = 1'b0;
        o_mem_rdata = '0;
        o_req_count = 0;
        forever begin
            @(negedge i_clk);
            if (i_mem_req && !o_mem_ack) begin
                o_req_count = o_req_count + 1;
                r_seed = next_rand(r_seed);
                delay  = 1 + int'(r_seed % MAX_DELAY);   // 1 to MAX_DELAY cycles
                repeat (delay) @(negedge i_clk);
                if (i_mem_pkt.wr) begin
                    for (int b = 0; b < WORD_BYTES; b++) begin
                        if (i_mem_pkt.be[b]) begin
                            mem[i_mem_pkt.addr][8*b +: 8] = i_mem_pkt.wdata[8*b +: 8];
                        end
                    end
                end else begin
                    o_mem_rdata = mem[i_mem_pkt.addr];
                end
                o_mem_ack = 1'b1;
                while (i_mem_req) @(negedge i_clk);     // cache drops req first
                o_mem_ack = 1'b0;
            end
        end
    end

endmodule

// ==== sim/tb_dcache.sv ====
`timescale 1ns/100ps

module tb_dcache
    import cache_cfg_pkg::*, cache_bus_pkg::*;
();

    localparam logic [31:0] SEED        = 32'h959b_dfe9;
    localparam int          NUM_RANDOM  = 400;
    localparam int          NUM_DIRECT  = 16;   // upper bound on directed transactions
    localparam int          MEM_DELAY   = 8;
    localparam int          TXN_CYCLES  = 40;
    localparam int          INIT_CYCLES = 200;
    localparam int          TIMEOUT     = (NUM_RANDOM + NUM_DIRECT) * TXN_CYCLES + INIT_CYCLES;
    localparam addr_t       WINDOW_BASE = 16'h3400;

    logic     clk;
    logic     rst;
    logic     cpu_req;
    cpu_req_t cpu_pkt;
    logic     cpu_ack;
    word_t    cpu_rdata;
    logic     mem_req;
    mem_req_t mem_pkt;
    logic     mem_ack;
    word_t    mem_rdata;
    int       mem_count;

    // reference state
    word_t    shadow [1 << ADDR_WIDTH];
    bit       written [1 << ADDR_WIDTH];
    bit       res_valid [NUM_LINES];
    tag_t     res_tag [NUM_LINES];
    int       exp_mem_count = 0;

    // handed from stimulus to the compare process
    bit       pend_read = 1'b0;
    word_t    pend_exp;
    addr_t    pend_addr;
    bit       ack_seen = 1'b0;
    int       reads_issued = 0;
    int       reads_checked = 0;
    int       cycle_count = 0;

    dcache_top i_dcache_top (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_cpu_req   (cpu_req),
        .i_cpu_pkt   (cpu_pkt),
        .o_cpu_ack   (cpu_ack),
        .o_cpu_rdata (cpu_rdata),
        .o_mem_req   (mem_req),
        .o_mem_pkt   (mem_pkt),
        .i_mem_ack   (mem_ack),
        .i_mem_rdata (mem_rdata)
    );

    tb_mem_model #(
        .MAX_DELAY (MEM_DELAY),
        .SEED      (SEED)
    ) u_mem (
        .i_clk       (clk),
        .i_mem_req   (mem_req),
        .i_mem_pkt   (mem_pkt),
        .o_mem_ack   (mem_ack),
        .o_mem_rdata (mem_rdata),
        .o_req_count (mem_count)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t initial_word(input addr_t a);
        return {~a, a ^ 16'h5a3c};     // backing memory contents at start
    endfunction

    function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
        word_t w;
        w = old_w;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (be[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    // every earlier byte write applied over the initial pattern
    function automatic word_t expected_word(input addr_t a);
        return written[a] ? shadow[a] : initial_word(a);
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_rdata(input word_t got, input word_t exp, input addr_t a);
        if (got !== exp) begin
            abort_run($sformatf("ERR @%0t: read of %h returned %h, expected %h",
                                $time, a, got, exp));
        end
    endtask

    task automatic check_mem_count(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR @%0t: %0d memory requests, expected %0d", $time, got, exp));
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERR @%0t: ack after %0d cycles, expected %0d", $time, got, exp));
        end
    endtask

    // one processor transaction, predicted before it is issued
    task automatic do_txn(input logic wr, input addr_t a, input word_t data, input be_t be,
                          output int latency);
        index_t idx;
        tag_t   tag;
        int     cycles;
        idx = a[INDEX_WIDTH-1:0];
        tag = a[ADDR_WIDTH-1:INDEX_WIDTH];
        if (wr) begin
            shadow[a]     = merge_bytes(expected_word(a), data, be);
            written[a]    = 1'b1;
            exp_mem_count = exp_mem_count + 1;      // write through, no allocate
        end else begin
            pend_exp  = expected_word(a);
            pend_addr = a;
            reads_issued = reads_issued + 1;
            if (!(res_valid[idx] && res_tag[idx] == tag)) begin
                exp_mem_count  = exp_mem_count + 1;  // miss fills the line
                res_valid[idx] = 1'b1;
                res_tag[idx]   = tag;
            end
        end
        pend_read     = !wr;
        cpu_pkt.wr    = wr;
        cpu_pkt.addr  = a;
        cpu_pkt.wdata = data;
        cpu_pkt.be    = be;
        cpu_req       = 1'b1;
        cycles        = 0;
        do begin
            @(negedge clk);
            cycles = cycles + 1;
        end while (!cpu_ack);
        latency = cycles - 1;       // edges after the one that sampled req
        cpu_req = 1'b0;
        check_mem_count(mem_count, exp_mem_count);
        while (cpu_ack) @(negedge clk);
    endtask

    // read data checked on the rise of ack
    always @(negedge clk) begin
        if (cpu_ack && !ack_seen && pend_read) begin
            check_rdata(cpu_rdata, pend_exp, pend_addr);
            reads_checked = reads_checked + 1;
        end
        ack_seen = cpu_ack;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT) begin
            abort_run($sformatf("timeout: cache stopped answering after %0d cycles", cycle_count));
        end
    end

    initial begin
        logic [31:0] rnd;
        int          lat;
        addr_t       a;
        logic        wr;
        be_t         be;
        rst     = 1'b1;
        cpu_req = 1'b0;
        cpu_pkt = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;

        do_txn(1'b0, 16'h0105, '0, '0, lat);            // cold read, one refill
        do_txn(1'b0, 16'h0105, '0, '0, lat);            // hit
        check_latency(lat, 2);

        do_txn(1'b1, 16'h0105, 32'hdead_beef, 4'b0101, lat);   // write hit
        do_txn(1'b0, 16'h0105, '0, '0, lat);
        do_txn(1'b1, 16'h0a17, 32'h1234_5678, 4'b1100, lat);   // write miss
        do_txn(1'b0, 16'h0a17, '0, '0, lat);            // still a miss, no allocate

        // same index, different tags
        for (int n = 0; n < 4; n++) begin
            do_txn(1'b0, (n % 2 == 0) ? 16'h0240 : 16'h0640, '0, '0, lat);
        end

        rnd = SEED;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            rnd = xorshift32(rnd);
            a   = WINDOW_BASE + addr_t'(rnd[6:0]);
            wr  = (rnd[9:8] == 2'b00);
            be  = (rnd[15:12] == 4'h0) ? 4'hf : rnd[15:12];
            rnd = xorshift32(rnd);
            do_txn(wr, a, rnd, be, lat);
        end

        if (reads_checked != reads_issued) begin
            abort_run($sformatf("only %0d of %0d reads reached the compare process",
                                reads_checked, reads_issued));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
logic/cache_cfg_pkg.sv
logic/cache_bus_pkg.sv
logic/fwd_ram.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv
